// File: verilog/efpga_glue_pkg.sv
// --------------------
// shared widths and counts for the eFPGA glue logic
// L2 accesses always land in region 1C0, only the low offset bits reach the fabric
// --------------------
package efpga_glue_pkg;

   localparam int CTRL_WIDTH        = 32;
   localparam int LINT_ADDR_WIDTH   = 20;
   localparam int LINT_GNT_DELAY    = 5;   // cycles of held req before gnt

   localparam int N_TCDM_PORTS      = 4;
   localparam int N_EVENTS          = 16;

   localparam int L2_ADDR_WIDTH     = 32;
   localparam int TCDM_OFFSET_WIDTH = 20;
   localparam int TCDM_REGION_WIDTH = L2_ADDR_WIDTH - TCDM_OFFSET_WIDTH;

   localparam logic [TCDM_REGION_WIDTH-1:0] TCDM_REGION = 12'h1C0;

   // one L2 address, seen whole or split into region and offset
   typedef union packed {
      logic [L2_ADDR_WIDTH-1:0] word;
      struct packed {
         logic [TCDM_REGION_WIDTH-1:0] region;
         logic [TCDM_OFFSET_WIDTH-1:0] offset;
      } fields;
   } tcdm_addr_u;

endpackage

// File: verilog/control_word_filter.sv
// --------------------
// word must be seen on 3 sampling edges in a row, output follows 4 cycles later
// shorter glitches never reach the fabric
// --------------------
`timescale 1ns/100ps

module control_word_filter import efpga_glue_pkg::*; (
   input  logic                  asic_clk_i,
   input  logic                  rst_n,
   input  logic [CTRL_WIDTH-1:0] control_i,
   output logic [CTRL_WIDTH-1:0] efpga_control_o
);

   logic [CTRL_WIDTH-1:0] ctrl_d1;
   logic [CTRL_WIDTH-1:0] ctrl_d2;
   logic                  ctrl_stable;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_d1         <= '0;
         ctrl_d2         <= '0;
         ctrl_stable     <= 1'b0;
         efpga_control_o <= '0;
      end else begin
         ctrl_d1     <= control_i;
         ctrl_d2     <= ctrl_d1;
         ctrl_stable <= (ctrl_d1 == control_i) && (ctrl_d2 == control_i);
         if (ctrl_stable) begin
            efpga_control_o <= ctrl_d1;   // d1 still holds the settled word
         end
      end
   end

endmodule

// File: verilog/lint_grant_gate.sv
// --------------------
// master holds req until gnt, then drops it for at least one cycle
// when disabled nothing reaches the bank and every request is granted at once
// --------------------
`timescale 1ns/100ps

module lint_grant_gate import efpga_glue_pkg::*; (
   input  logic                       asic_clk_i,
   input  logic                       rst_n,
   input  logic                       lint_enable_i,
   input  logic                       lint_req_i,
   input  logic [LINT_ADDR_WIDTH-1:0] lint_addr_i,
   input  logic                       lint_wen_i,
   input  logic [31:0]                lint_wdata_i,
   input  logic [3:0]                 lint_be_i,
   output logic                       lint_gnt_o,
   output logic                       lint_r_valid_o,
   output logic [31:0]                lint_rdata_o,
   output logic                       fab_req_o,
   output logic [LINT_ADDR_WIDTH-1:0] fab_addr_o,
   output logic                       fab_wen_o,
   output logic [31:0]                fab_wdata_o,
   output logic [3:0]                 fab_be_o,
   input  logic [31:0]                fab_rdata_i,
   input  logic                       fab_r_valid_i
);

   logic [LINT_GNT_DELAY-1:0] req_hold;   // one bit per cycle of held req

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         req_hold <= '0;
      end else if (!lint_req_i || !lint_enable_i) begin
         req_hold <= '0;
      end else begin
         req_hold <= {req_hold[LINT_GNT_DELAY-2:0], 1'b1};
      end
   end

   assign lint_gnt_o     = lint_enable_i ? (req_hold[LINT_GNT_DELAY-1] & lint_req_i) : lint_req_i;
   assign lint_r_valid_o = lint_enable_i ? fab_r_valid_i : 1'b1;
   assign lint_rdata_o   = fab_rdata_i;

   // only the first cycle of a request goes through
   assign fab_req_o   = lint_enable_i & lint_req_i & ~(req_hold[0] | req_hold[1]);
   assign fab_addr_o  = lint_addr_i;
   assign fab_wen_o   = lint_wen_i;
   assign fab_wdata_o = lint_wdata_i;
   assign fab_be_o    = lint_be_i;

endmodule

// File: verilog/lint_scratch_bank.sv
// --------------------
// 16 words at addr[5:2], always ready
// wen high means read, each access gives one valid pulse
// --------------------
`timescale 1ns/100ps

module lint_scratch_bank import efpga_glue_pkg::*; (
   input  logic                       asic_clk_i,
   input  logic                       rst_n,
   input  logic                       fab_req_i,
   input  logic [LINT_ADDR_WIDTH-1:0] fab_addr_i,
   input  logic                       fab_wen_i,
   input  logic [31:0]                fab_wdata_i,
   input  logic [3:0]                 fab_be_i,
   output logic [31:0]                fab_rdata_o,
   output logic                       fab_r_valid_o
);

   logic [31:0] mem [16];
   logic [3:0]  word_sel;

   assign word_sel = fab_addr_i[5:2];

   always_ff @(posedge asic_clk_i) begin
      if (fab_req_i) begin
         if (fab_wen_i) begin
            fab_rdata_o <= mem[word_sel];
         end else begin
            for (int b = 0; b < 4; b++) begin
               if (fab_be_i[b]) begin
                  mem[word_sel][8*b +: 8] <= fab_wdata_i[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         fab_r_valid_o <= 1'b0;
      end else begin
         fab_r_valid_o <= fab_req_i;   // writes also answer
      end
   end

endmodule

// File: verilog/tcdm_port_bridge.sv
// --------------------
// one entry slot between fabric and L2, fabric gnt means slot empty
// slot outputs hold until l2_gnt_i, wen high means read
// --------------------
`timescale 1ns/100ps

module tcdm_port_bridge import efpga_glue_pkg::*; (
   input  logic                         asic_clk_i,
   input  logic                         rst_n,
   input  logic                         enable_i,
   input  logic                         fab_req_i,
   input  logic [TCDM_OFFSET_WIDTH-1:0] fab_addr_i,
   input  logic                         fab_wen_i,
   input  logic [31:0]                  fab_wdata_i,
   input  logic [3:0]                   fab_be_i,
   output logic                         fab_gnt_o,
   output logic [31:0]                  fab_rdata_o,
   output logic                         fab_read_valid_o,
   output logic                         l2_req_o,
   output logic [L2_ADDR_WIDTH-1:0]     l2_addr_o,
   output logic                         l2_wen_o,
   output logic [31:0]                  l2_wdata_o,
   output logic [3:0]                   l2_be_o,
   input  logic                         l2_gnt_i,
   input  logic                         l2_r_valid_i,
   input  logic [31:0]                  l2_r_rdata_i
);

   logic                         slot_full;
   logic [TCDM_OFFSET_WIDTH-1:0] slot_offset;
   logic                         accept;
   logic                         last_wen;
   tcdm_addr_u                   l2_addr;

   assign fab_gnt_o = ~slot_full;
   assign accept    = enable_i & fab_req_i & fab_gnt_o;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         slot_full <= 1'b0;
      end else if (accept) begin
         slot_full <= 1'b1;
      end else if (l2_gnt_i) begin
         slot_full <= 1'b0;
      end
   end

   always_ff @(posedge asic_clk_i) begin
      if (accept) begin
         slot_offset <= fab_addr_i;
         l2_wen_o    <= fab_wen_i;
         l2_wdata_o  <= fab_wdata_i;
         l2_be_o     <= fab_be_i;
      end
   end

   always_comb begin
      l2_addr.fields.region = TCDM_REGION;
      l2_addr.fields.offset = slot_offset;
   end

   assign l2_req_o  = slot_full;
   assign l2_addr_o = l2_addr.word;

   // remembers the direction of the pending response
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         last_wen <= 1'b1;
      end else if (l2_req_o) begin
         last_wen <= l2_wen_o;
      end
   end

   assign fab_read_valid_o = l2_r_valid_i & last_wen;   // writes give no valid
   assign fab_rdata_o      = l2_r_rdata_i;

endmodule

// File: verilog/event_edge_sync.sv
// --------------------
// one cycle pulse per rising edge of an enabled event
// --------------------
`timescale 1ns/100ps

module event_edge_sync import efpga_glue_pkg::*; #(
   parameter int N_EVENTS = efpga_glue_pkg::N_EVENTS
) (
   input  logic                asic_clk_i,
   input  logic                rst_n,
   input  logic                events_enable_i,
   input  logic [N_EVENTS-1:0] fab_events_i,
   output logic [N_EVENTS-1:0] efpga_event_o
);

   logic [N_EVENTS-1:0] events_masked;
   logic [N_EVENTS-1:0] events_prev;

   assign events_masked = fab_events_i & {N_EVENTS{events_enable_i}};

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         events_prev   <= '0;
         efpga_event_o <= '0;
      end else begin
         events_prev   <= events_masked;
         efpga_event_o <= events_masked & ~events_prev;   // rising edges only
      end
   end

endmodule

// File: verilog/efpga_subsystem.sv
// --------------------
// ASIC side glue of the eFPGA, single clock domain
// fabric side TCDM and event signals come straight in as ports
// --------------------
`timescale 1ns/100ps

module efpga_subsystem import efpga_glue_pkg::*; #(
   parameter int N_PORTS  = N_TCDM_PORTS,
   parameter int N_EVENTS = efpga_glue_pkg::N_EVENTS
) (
   input  logic                                           asic_clk_i,
   input  logic                                           rst_n,

   input  logic [CTRL_WIDTH-1:0]                          control_i,
   output logic [CTRL_WIDTH-1:0]                          efpga_control_o,

   input  logic                                           lint_enable_i,
   input  logic                                           lint_req_i,
   input  logic [LINT_ADDR_WIDTH-1:0]                     lint_addr_i,
   input  logic                                           lint_wen_i,
   input  logic [31:0]                                    lint_wdata_i,
   input  logic [3:0]                                     lint_be_i,
   output logic                                           lint_gnt_o,
   output logic                                           lint_r_valid_o,
   output logic [31:0]                                    lint_rdata_o,

   input  logic [N_PORTS-1:0]                             tcdm_enable_i,
   input  logic [N_PORTS-1:0]                             fab_tcdm_req_i,
   input  logic [N_PORTS-1:0][TCDM_OFFSET_WIDTH-1:0]      fab_tcdm_addr_i,
   input  logic [N_PORTS-1:0]                             fab_tcdm_wen_i,
   input  logic [N_PORTS-1:0][31:0]                       fab_tcdm_wdata_i,
   input  logic [N_PORTS-1:0][3:0]                        fab_tcdm_be_i,
   output logic [N_PORTS-1:0]                             fab_tcdm_gnt_o,
   output logic [N_PORTS-1:0][31:0]                       fab_tcdm_rdata_o,
   output logic [N_PORTS-1:0]                             fab_tcdm_read_valid_o,

   output logic [N_PORTS-1:0]                             l2_req_o,
   output logic [N_PORTS-1:0][L2_ADDR_WIDTH-1:0]          l2_addr_o,
   output logic [N_PORTS-1:0]                             l2_wen_o,
   output logic [N_PORTS-1:0][31:0]                       l2_wdata_o,
   output logic [N_PORTS-1:0][3:0]                        l2_be_o,
   input  logic [N_PORTS-1:0]                             l2_gnt_i,
   input  logic [N_PORTS-1:0]                             l2_r_valid_i,
   input  logic [N_PORTS-1:0][31:0]                       l2_r_rdata_i,

   input  logic                                           events_enable_i,
   input  logic [N_EVENTS-1:0]                            fab_events_i,
   output logic [N_EVENTS-1:0]                            efpga_event_o
);

   // lint path between gate and scratch bank
   logic                       fab_req;
   logic [LINT_ADDR_WIDTH-1:0] fab_addr;
   logic                       fab_wen;
   logic [31:0]                fab_wdata;
   logic [3:0]                 fab_be;
   logic [31:0]                fab_rdata;
   logic                       fab_r_valid;

   control_word_filter u_ctrl_filter (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .control_i       (control_i),
      .efpga_control_o (efpga_control_o)
   );

   lint_grant_gate u_lint_gate (
      .asic_clk_i     (asic_clk_i),
      .rst_n          (rst_n),
      .lint_enable_i  (lint_enable_i),
      .lint_req_i     (lint_req_i),
      .lint_addr_i    (lint_addr_i),
      .lint_wen_i     (lint_wen_i),
      .lint_wdata_i   (lint_wdata_i),
      .lint_be_i      (lint_be_i),
      .lint_gnt_o     (lint_gnt_o),
      .lint_r_valid_o (lint_r_valid_o),
      .lint_rdata_o   (lint_rdata_o),
      .fab_req_o      (fab_req),
      .fab_addr_o     (fab_addr),
      .fab_wen_o      (fab_wen),
      .fab_wdata_o    (fab_wdata),
      .fab_be_o       (fab_be),
      .fab_rdata_i    (fab_rdata),
      .fab_r_valid_i  (fab_r_valid)
   );

   lint_scratch_bank u_lint_bank (
      .asic_clk_i    (asic_clk_i),
      .rst_n         (rst_n),
      .fab_req_i     (fab_req),
      .fab_addr_i    (fab_addr),
      .fab_wen_i     (fab_wen),
      .fab_wdata_i   (fab_wdata),
      .fab_be_i      (fab_be),
      .fab_rdata_o   (fab_rdata),
      .fab_r_valid_o (fab_r_valid)
   );

   for (genvar g = 0; g < N_PORTS; g++) begin : g_tcdm
      tcdm_port_bridge u_bridge (
         .asic_clk_i       (asic_clk_i),
         .rst_n            (rst_n),
         .enable_i         (tcdm_enable_i[g]),   // each port on its own enable
         .fab_req_i        (fab_tcdm_req_i[g]),
         .fab_addr_i       (fab_tcdm_addr_i[g]),
         .fab_wen_i        (fab_tcdm_wen_i[g]),
         .fab_wdata_i      (fab_tcdm_wdata_i[g]),
         .fab_be_i         (fab_tcdm_be_i[g]),
         .fab_gnt_o        (fab_tcdm_gnt_o[g]),
         .fab_rdata_o      (fab_tcdm_rdata_o[g]),
         .fab_read_valid_o (fab_tcdm_read_valid_o[g]),
         .l2_req_o         (l2_req_o[g]),
         .l2_addr_o        (l2_addr_o[g]),
         .l2_wen_o         (l2_wen_o[g]),
         .l2_wdata_o       (l2_wdata_o[g]),
         .l2_be_o          (l2_be_o[g]),
         .l2_gnt_i         (l2_gnt_i[g]),
         .l2_r_valid_i     (l2_r_valid_i[g]),
         .l2_r_rdata_i     (l2_r_rdata_i[g])
      );
   end

   event_edge_sync #(
      .N_EVENTS (N_EVENTS)
   ) u_event_sync (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .events_enable_i (events_enable_i),
      .fab_events_i    (fab_events_i),
      .efpga_event_o   (efpga_event_o)
   );

endmodule

// File: sim/efpga_subsystem_props.sv
// --------------------
// bound into efpga_subsystem, checks L2 hold, event width and lint bypass
// --------------------
`timescale 1ns/100ps

module efpga_subsystem_props import efpga_glue_pkg::*; #(
   parameter int N_PORTS  = N_TCDM_PORTS,
   parameter int N_EVENTS = efpga_glue_pkg::N_EVENTS
) (
   input logic                                  asic_clk_i,
   input logic                                  rst_n,
   input logic                                  lint_enable_i,
   input logic                                  lint_req_i,
   input logic                                  lint_gnt_o,
   input logic [N_PORTS-1:0]                    l2_req_o,
   input logic [N_PORTS-1:0][L2_ADDR_WIDTH-1:0] l2_addr_o,
   input logic [N_PORTS-1:0]                    l2_wen_o,
   input logic [N_PORTS-1:0][31:0]              l2_wdata_o,
   input logic [N_PORTS-1:0][3:0]               l2_be_o,
   input logic [N_PORTS-1:0]                    l2_gnt_i,
   input logic [N_EVENTS-1:0]                   efpga_event_o
);

   for (genvar p = 0; p < N_PORTS; p++) begin : g_port
      a_l2_hold : assert property (@(posedge asic_clk_i) disable iff (!rst_n)
         (l2_req_o[p] && !l2_gnt_i[p]) |=> (l2_req_o[p] && $stable(l2_addr_o[p])
            && $stable(l2_wen_o[p]) && $stable(l2_wdata_o[p]) && $stable(l2_be_o[p])))
         else $error("l2 request on port %0d changed before grant", p);
   end

   a_event_single : assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      (efpga_event_o & $past(efpga_event_o)) == '0)
      else $error("event pulse lasted two cycles");

   a_lint_bypass : assert property (@(posedge asic_clk_i) disable iff (!rst_n)
      !lint_enable_i |-> (lint_gnt_o == lint_req_i))
      else $error("lint grant differs from request while bypassed");

endmodule

bind efpga_subsystem efpga_subsystem_props #(
   .N_PORTS  (N_PORTS),
   .N_EVENTS (N_EVENTS)
) u_props (
   .asic_clk_i    (asic_clk_i),
   .rst_n         (rst_n),
   .lint_enable_i (lint_enable_i),
   .lint_req_i    (lint_req_i),
   .lint_gnt_o    (lint_gnt_o),
   .l2_req_o      (l2_req_o),
   .l2_addr_o     (l2_addr_o),
   .l2_wen_o      (l2_wen_o),
   .l2_wdata_o    (l2_wdata_o),
   .l2_be_o       (l2_be_o),
   .l2_gnt_i      (l2_gnt_i),
   .efpga_event_o (efpga_event_o)
);

// File: sim/tb_efpga_subsystem.sv
// --------------------
// drives the fabric side in place of the eFPGA
// L2 answers after 0 to 3 cycles, bank words start unknown and are all written first
// --------------------
`timescale 1ns/100ps

module tb_efpga_subsystem import efpga_glue_pkg::*; ();

   localparam int TEST_CYCLES = 1250;                 // generous bound on all phases
   localparam int TIMEOUT_NS  = TEST_CYCLES * 4 * 4;  // about 20 us

   logic asic_clk_i = 1'b0;
   logic rst_n;
   logic [CTRL_WIDTH-1:0] control_i, efpga_control_o;
   logic lint_enable_i, lint_req_i, lint_wen_i, lint_gnt_o, lint_r_valid_o;
   logic [LINT_ADDR_WIDTH-1:0] lint_addr_i;
   logic [31:0] lint_wdata_i, lint_rdata_o;
   logic [3:0] lint_be_i;
   logic [N_TCDM_PORTS-1:0] tcdm_enable_i, fab_tcdm_req_i, fab_tcdm_wen_i;
   logic [N_TCDM_PORTS-1:0][TCDM_OFFSET_WIDTH-1:0] fab_tcdm_addr_i;
   logic [N_TCDM_PORTS-1:0][31:0] fab_tcdm_wdata_i, fab_tcdm_rdata_o, l2_wdata_o;
   logic [N_TCDM_PORTS-1:0][3:0] fab_tcdm_be_i, l2_be_o;
   logic [N_TCDM_PORTS-1:0] fab_tcdm_gnt_o, fab_tcdm_read_valid_o, l2_req_o, l2_wen_o;
   logic [N_TCDM_PORTS-1:0][L2_ADDR_WIDTH-1:0] l2_addr_o;
   logic [N_TCDM_PORTS-1:0] l2_gnt_i = '0;
   logic [N_TCDM_PORTS-1:0] l2_r_valid_i = '0;
   logic [N_TCDM_PORTS-1:0][31:0] l2_r_rdata_i = '0;
   logic events_enable_i;
   logic [N_EVENTS-1:0] fab_events_i, efpga_event_o;

   logic [31:0] lfsr_state = 32'h5b48;
   int error_count = 0;
   int check_count = 0;
   logic [31:0] model_mem [16];
   logic [CTRL_WIDTH-1:0] ctrl_h1, ctrl_h2, ctrl_h3, ctrl_model;
   logic [N_EVENTS-1:0] ev_prev, ev_model;
   int unsigned gnt_wait [N_TCDM_PORTS];
   logic [31:0] resp_data [N_TCDM_PORTS];
   int l2_count [N_TCDM_PORTS];
   int rvalid_count [N_TCDM_PORTS];
   logic [TCDM_OFFSET_WIDTH-1:0] exp_offset [N_TCDM_PORTS];
   logic exp_wen [N_TCDM_PORTS];
   logic [31:0] exp_wdata [N_TCDM_PORTS];
   logic [3:0] exp_be [N_TCDM_PORTS];

   always #2 asic_clk_i = ~asic_clk_i;

   efpga_subsystem #(
      .N_PORTS  (N_TCDM_PORTS),
      .N_EVENTS (N_EVENTS)
   ) dut (.*);

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      end
      return r;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] be);
      logic [31:0] w;
      w = old_word;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) w[8*b +: 8] = new_word[8*b +: 8];
      end
      return w;
   endfunction

   // output takes a word once the last three samples agree
   function automatic logic [CTRL_WIDTH-1:0] filter_next(input logic [CTRL_WIDTH-1:0] s1,
                                                         input logic [CTRL_WIDTH-1:0] s2,
                                                         input logic [CTRL_WIDTH-1:0] s3,
                                                         input logic [CTRL_WIDTH-1:0] prev);
      return (s1 == s2 && s2 == s3) ? s1 : prev;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("error at %0t ns: %s", $time, what);
   endtask

   // reference models for the filter and the event pulses
   always @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_h1 = '0;
         ctrl_h2 = '0;
         ctrl_h3 = '0;
         ctrl_model = '0;
         ev_prev = '0;
         ev_model = '0;
      end else begin
         ctrl_model = filter_next(ctrl_h1, ctrl_h2, ctrl_h3, ctrl_model);
         ctrl_h3 = ctrl_h2;
         ctrl_h2 = ctrl_h1;
         ctrl_h1 = control_i;
         ev_model = (fab_events_i & {N_EVENTS{events_enable_i}}) & ~ev_prev;
         ev_prev = fab_events_i & {N_EVENTS{events_enable_i}};
      end
   end

   always @(negedge asic_clk_i) begin
      if (rst_n) begin
         check_value("efpga_control_o", efpga_control_o, ctrl_model);
         check_value("efpga_event_o", 32'(efpga_event_o), 32'(ev_model));
         for (int p = 0; p < N_TCDM_PORTS; p++) begin
            if (fab_tcdm_read_valid_o[p]) begin
               rvalid_count[p]++;
               if (!exp_wen[p]) report_failure("read valid after a tcdm write");
               check_value("fab_tcdm_rdata_o", fab_tcdm_rdata_o[p], resp_data[p]);
            end
         end
      end
   end

   // L2 responder grants after a random wait and answers one cycle later
   always @(posedge asic_clk_i) begin
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
         l2_gnt_i[p] <= 1'b0;
         l2_r_valid_i[p] <= 1'b0;
         if (!rst_n) begin
            gnt_wait[p] = 0;
         end else if (l2_gnt_i[p]) begin
            l2_count[p]++;
            check_value("l2_addr_o", l2_addr_o[p], {TCDM_REGION, exp_offset[p]});
            check_value("l2_wen_o", 32'(l2_wen_o[p]), 32'(exp_wen[p]));
            check_value("l2_wdata_o", l2_wdata_o[p], exp_wdata[p]);
            check_value("l2_be_o", 32'(l2_be_o[p]), 32'(exp_be[p]));
            l2_r_valid_i[p] <= 1'b1;
            l2_r_rdata_i[p] <= resp_data[p];
         end else if (l2_req_o[p]) begin
            if (gnt_wait[p] == 0) begin
               l2_gnt_i[p] <= 1'b1;
               gnt_wait[p] = rand_bits(2);
               resp_data[p] = rand_bits(32);
            end else begin
               gnt_wait[p]--;
            end
         end
      end
   end

   task automatic lint_access(input logic wen, input logic [3:0] word, input logic [31:0] data,
                              input logic [3:0] be, output logic [31:0] rdata);
      int waited;
      int valid_count;
      waited = 0;
      valid_count = 0;
      rdata = '0;
      @(posedge asic_clk_i);
      lint_req_i <= 1'b1;
      lint_wen_i <= wen;
      lint_addr_i <= {14'(rand_bits(14)), word, 2'b00};   // only bits 5:2 select
      lint_wdata_i <= data;
      lint_be_i <= be;
      @(negedge asic_clk_i);
      if (!lint_enable_i) begin
         check_value("lint_gnt_o", 32'(lint_gnt_o), 32'd1);
         check_value("lint_r_valid_o", 32'(lint_r_valid_o), 32'd1);
      end
      while (!lint_gnt_o) begin
         if (lint_r_valid_o) begin
            valid_count++;
            rdata = lint_rdata_o;
         end
         waited++;
         @(negedge asic_clk_i);
      end
      if (lint_enable_i && waited < LINT_GNT_DELAY) report_failure("lint grant came too early");
      if (lint_enable_i) begin
         check_value("lint_r_valid_o pulses", 32'(valid_count), 32'd1);
      end
      @(posedge asic_clk_i);
      lint_req_i <= 1'b0;
      @(posedge asic_clk_i);
   endtask

   task automatic tcdm_issue(input int p, input logic wen);
      int start_l2;
      int start_rv;
      int waited;
      exp_offset[p] = 20'(rand_bits(20));
      exp_wen[p] = wen;
      exp_wdata[p] = rand_bits(32);
      exp_be[p] = 4'(rand_bits(4));
      start_l2 = l2_count[p];
      start_rv = rvalid_count[p];
      waited = 0;
      @(posedge asic_clk_i);
      fab_tcdm_req_i[p] <= 1'b1;
      fab_tcdm_addr_i[p] <= exp_offset[p];
      fab_tcdm_wen_i[p] <= wen;
      fab_tcdm_wdata_i[p] <= exp_wdata[p];
      fab_tcdm_be_i[p] <= exp_be[p];
      @(negedge asic_clk_i);
      while (!fab_tcdm_gnt_o[p]) @(negedge asic_clk_i);
      @(posedge asic_clk_i);
      fab_tcdm_req_i[p] <= 1'b0;
      @(negedge asic_clk_i);
      if (tcdm_enable_i[p]) begin
         check_value("fab_tcdm_gnt_o", 32'(fab_tcdm_gnt_o[p]), 32'd0);   // slot waits for L2
         while (l2_count[p] == start_l2 && waited < 20) begin
            waited++;
            @(negedge asic_clk_i);
         end
         repeat (4) @(negedge asic_clk_i);
         check_value("l2 request count", 32'(l2_count[p] - start_l2), 32'd1);
         check_value("read valid count", 32'(rvalid_count[p] - start_rv), 32'(wen));
         check_value("fab_tcdm_gnt_o", 32'(fab_tcdm_gnt_o[p]), 32'd1);
      end else begin
         check_value("fab_tcdm_gnt_o", 32'(fab_tcdm_gnt_o[p]), 32'd1);
         repeat (8) begin
            check_value("l2_req_o on disabled port", 32'(l2_req_o[p]), 32'd0);
            @(negedge asic_clk_i);
         end
         check_value("l2 request count", 32'(l2_count[p] - start_l2), 32'd0);
      end
   endtask

   initial begin
      logic [31:0] word;
      logic [31:0] data;
      logic [31:0] rdata;
      logic [3:0] be;
      logic [3:0] w;
      rst_n = 1'b0;
      control_i = '0;
      lint_enable_i = 1'b1;
      lint_req_i = 1'b0;
      lint_addr_i = '0;
      lint_wen_i = 1'b0;
      lint_wdata_i = '0;
      lint_be_i = '0;
      tcdm_enable_i = '1;
      fab_tcdm_req_i = '0;
      fab_tcdm_addr_i = '0;
      fab_tcdm_wen_i = '0;
      fab_tcdm_wdata_i = '0;
      fab_tcdm_be_i = '0;
      events_enable_i = 1'b0;
      fab_events_i = '0;
      repeat (10) @(posedge asic_clk_i);
      rst_n <= 1'b1;

      @(negedge asic_clk_i);
      check_value("lint_gnt_o", 32'(lint_gnt_o), 32'd0);
      check_value("lint_r_valid_o", 32'(lint_r_valid_o), 32'd0);
      check_value("l2_req_o", 32'(l2_req_o), 32'd0);
      check_value("fab_tcdm_read_valid_o", 32'(fab_tcdm_read_valid_o), 32'd0);
      check_value("efpga_event_o", 32'(efpga_event_o), 32'd0);
      check_value("efpga_control_o", efpga_control_o, 32'd0);

      // control word, then glitches of 1 and 2 cycles
      word = rand_bits(32);
      @(posedge asic_clk_i) control_i <= word;
      repeat (8) @(posedge asic_clk_i);
      for (int len = 1; len <= 2; len++) begin
         control_i <= ~word;
         repeat (len) @(posedge asic_clk_i);
         control_i <= word;
         repeat (8) @(posedge asic_clk_i);
         check_value("efpga_control_o", efpga_control_o, word);
      end

      // lint path enabled
      for (int i = 0; i < 16; i++) begin
         data = rand_bits(32);
         lint_access(1'b0, 4'(i), data, 4'hF, rdata);
         model_mem[i] = data;
      end
      for (int i = 0; i < 16; i++) begin
         w = 4'(rand_bits(4));
         data = rand_bits(32);
         be = 4'(rand_bits(4));
         lint_access(1'b0, w, data, be, rdata);
         model_mem[w] = merge_bytes(model_mem[w], data, be);
      end
      for (int i = 0; i < 16; i++) begin
         lint_access(1'b1, 4'(i), 32'd0, 4'hF, rdata);
         check_value("lint_rdata_o", rdata, model_mem[i]);
      end

      // bypassed lint path leaves the bank untouched
      @(posedge asic_clk_i) lint_enable_i <= 1'b0;
      lint_access(1'b0, 4'd3, ~model_mem[3], 4'hF, rdata);
      @(posedge asic_clk_i) lint_enable_i <= 1'b1;
      lint_access(1'b1, 4'd3, 32'd0, 4'hF, rdata);
      check_value("lint_rdata_o", rdata, model_mem[3]);

      // tcdm ports, then port 2 disabled
      for (int p = 0; p < N_TCDM_PORTS; p++) begin
         for (int k = 0; k < 4; k++) tcdm_issue(p, k[0]);
      end
      @(posedge asic_clk_i) tcdm_enable_i <= 4'b1011;
      tcdm_issue(2, 1'b1);
      tcdm_issue(2, 1'b0);

      // events enabled, then masked
      @(posedge asic_clk_i) events_enable_i <= 1'b1;
      repeat (40) @(posedge asic_clk_i) fab_events_i <= 16'(rand_bits(16));
      events_enable_i <= 1'b0;
      repeat (20) @(posedge asic_clk_i) fab_events_i <= 16'(rand_bits(16));
      repeat (4) @(posedge asic_clk_i);

      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("error: watchdog expired, the run did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: filelist.f
verilog/efpga_glue_pkg.sv
verilog/control_word_filter.sv
verilog/lint_grant_gate.sv
verilog/lint_scratch_bank.sv
verilog/tcdm_port_bridge.sv
verilog/event_edge_sync.sv
verilog/efpga_subsystem.sv
sim/efpga_subsystem_props.sv
sim/tb_efpga_subsystem.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_efpga_subsystem \
   -f filelist.f -Mdir obj_dir -o tb_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
! grep -q "TEST FAILED" sim.log && grep -q "TEST PASSED" sim.log \
   && exit 0 \
   || { echo "simulation failed"; exit 1; }
